//--- logic/alu.sv
`timescale 1ns/10ps

module alu (
	input mipsPkg::word a,
	input mipsPkg::word b,
	input mipsPkg::aluOp op,
	output mipsPkg::word result,
	output logic zero
);

	always_comb begin
		case (op)
			mipsPkg::ALU_ADD: result = a + b;
			mipsPkg::ALU_SUB: result = a - b;
			mipsPkg::ALU_AND: result = a & b;
			mipsPkg::ALU_OR: result = a | b;
			// signed compare
			mipsPkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- logic/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
	input mipsPkg::opcode op,
	input mipsPkg::functCode funct,
	output logic regWrite,
	output logic regDst,
	output logic aluSrc,
	output logic memWrite,
	output logic memToReg,
	output logic branch,
	output logic jump,
	output mipsPkg::aluOp aluControl
);

	always_comb begin
		// anything not listed is a no-op
		regWrite = 1'b0;
		regDst = 1'b0;
		aluSrc = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		aluControl = mipsPkg::ALU_ADD;
		case (op)
			mipsPkg::OP_RTYPE: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					mipsPkg::FN_ADDU: aluControl = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUBU: aluControl = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: aluControl = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: aluControl = mipsPkg::ALU_OR;
					mipsPkg::FN_SLT: aluControl = mipsPkg::ALU_SLT;
					default: regWrite = 1'b0;
				endcase
			end
			mipsPkg::OP_ADDIU: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
			end
			mipsPkg::OP_LW: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				memToReg = 1'b1;
			end
			mipsPkg::OP_SW: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			mipsPkg::OP_BEQ: begin
				branch = 1'b1;
				aluControl = mipsPkg::ALU_SUB;
			end
			mipsPkg::OP_J: jump = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- logic/datapath.sv
`timescale 1ns/10ps

module datapath (
	input logic clk,
	input logic reset,
	input mipsPkg::word instrF,
	input mipsPkg::word readDataM,
	input logic stallMem,
	output mipsPkg::word pcF,
	output logic memWriteM,
	output mipsPkg::word aluOutM,
	output mipsPkg::word writeDataM,
	output mipsPkg::word debugWbPc,
	output logic [3:0] debugWbRfWen,
	output mipsPkg::regNum debugWbRfWnum,
	output mipsPkg::word debugWbRfWdata,
	hazardIf.pipe hz
);

	mipsPkg::word pcPlus4F, pcNextF;
	mipsPkg::word instrD, pcD, pcPlus4D, rd1D, rd2D, srcAD, srcBD;
	mipsPkg::word signImmD, pcBranchD, pcJumpD;
	logic regWriteD, regDstD, aluSrcD, memWriteD, memToRegD, jumpD, takenD;
	mipsPkg::aluOp aluControlD;
	mipsPkg::word pcE, rd1E, rd2E, signImmE, srcAE, srcBE, writeDataE, aluOutE;
	mipsPkg::regNum rdE;
	logic regDstE, aluSrcE, memWriteE;
	mipsPkg::aluOp aluControlE;
	mipsPkg::word pcM, pcW, aluOutW, readDataW, resultW;
	logic memToRegW;

	function automatic mipsPkg::word pickFwd(input mipsPkg::fwdSel sel,
			input mipsPkg::word regVal, input mipsPkg::word memVal,
			input mipsPkg::word wbVal);
		case (sel)
			mipsPkg::FWD_MEM: return memVal;
			mipsPkg::FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	//////////////////////////////
	// fetch
	assign pcPlus4F = pcF + 32'd4;

	// redirect from decode wins over sequential fetch
	always_comb begin
		if (jumpD)
			pcNextF = pcJumpD;
		else if (takenD)
			pcNextF = pcBranchD;
		else
			pcNextF = pcPlus4F;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pcF <= mipsPkg::RESET_PC;
		else if (!hz.stallF)
			pcF <= pcNextF;
	end

	//////////////////////////////
	// decode
	always_ff @(posedge clk) begin
		if (reset)
			instrD <= '0;
		else if (!hz.stallD)
			instrD <= hz.flushD ? '0 : instrF;
	end

	always_ff @(posedge clk) begin
		if (!hz.stallD) begin
			pcD <= pcF;
			pcPlus4D <= pcPlus4F;
		end
	end

	assign hz.rsD = instrD[25:21];
	assign hz.rtD = instrD[20:16];

	controlDecoder decoder (
		.op(instrD[31:26]), .funct(instrD[5:0]),
		.regWrite(regWriteD), .regDst(regDstD), .aluSrc(aluSrcD),
		.memWrite(memWriteD), .memToReg(memToRegD), .branch(hz.branchD),
		.jump(jumpD), .aluControl(aluControlD)
	);

	regFile regs (
		.clk(clk), .we(hz.regWriteW),
		.ra1(hz.rsD), .ra2(hz.rtD), .wa(hz.writeRegW), .wd(resultW),
		.rd1(rd1D), .rd2(rd2D)
	);

	assign signImmD = {{16{instrD[15]}}, instrD[15:0]};
	assign pcBranchD = pcPlus4D + {signImmD[29:0], 2'b00};
	assign pcJumpD = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// branch operands may come early from memory stage
	assign srcAD = hz.forwardAD ? aluOutM : rd1D;
	assign srcBD = hz.forwardBD ? aluOutM : rd2D;
	assign takenD = hz.branchD && (srcAD == srcBD);
	assign hz.redirectD = jumpD | takenD;

	//////////////////////////////
	// execute
	always_ff @(posedge clk) begin
		if (reset || (hz.flushE && !hz.stallE)) begin
			hz.regWriteE <= 1'b0;
			hz.memToRegE <= 1'b0;
			memWriteE <= 1'b0;
			aluSrcE <= 1'b0;
			regDstE <= 1'b0;
			aluControlE <= mipsPkg::ALU_ADD;
		end else if (!hz.stallE) begin
			hz.regWriteE <= regWriteD;
			hz.memToRegE <= memToRegD;
			memWriteE <= memWriteD;
			aluSrcE <= aluSrcD;
			regDstE <= regDstD;
			aluControlE <= aluControlD;
		end
	end

	always_ff @(posedge clk) begin
		if (!hz.stallE) begin
			pcE <= pcD;
			rd1E <= rd1D;
			rd2E <= rd2D;
			signImmE <= signImmD;
			hz.rsE <= hz.rsD;
			hz.rtE <= hz.rtD;
			rdE <= instrD[15:11];
		end
	end

	assign srcAE = pickFwd(hz.forwardAE, rd1E, aluOutM, resultW);
	assign writeDataE = pickFwd(hz.forwardBE, rd2E, aluOutM, resultW);
	assign srcBE = aluSrcE ? signImmE : writeDataE;
	assign hz.writeRegE = regDstE ? rdE : hz.rtE;

	alu exAlu (.a(srcAE), .b(srcBE), .op(aluControlE), .result(aluOutE), .zero());

	//////////////////////////////
	// memory
	always_ff @(posedge clk) begin
		if (reset) begin
			hz.regWriteM <= 1'b0;
			hz.memToRegM <= 1'b0;
			memWriteM <= 1'b0;
		end else if (!hz.stallM) begin
			hz.regWriteM <= hz.regWriteE;
			hz.memToRegM <= hz.memToRegE;
			memWriteM <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		if (!hz.stallM) begin
			pcM <= pcE;
			aluOutM <= aluOutE;
			writeDataM <= writeDataE;
			hz.writeRegM <= hz.writeRegE;
		end
	end

	//////////////////////////////
	// writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			hz.regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else if (!hz.stallW) begin
			hz.regWriteW <= hz.regWriteM;
			memToRegW <= hz.memToRegM;
		end
	end

	always_ff @(posedge clk) begin
		if (!hz.stallW) begin
			pcW <= pcM;
			aluOutW <= aluOutM;
			readDataW <= readDataM;
			hz.writeRegW <= hz.writeRegM;
		end
	end

	assign resultW = memToRegW ? readDataW : aluOutW;

	// a frozen writeback is reported once, when the stall drops
	assign debugWbPc = pcW;
	assign debugWbRfWen = {4{hz.regWriteW & ~stallMem}};
	assign debugWbRfWnum = hz.writeRegW;
	// $0 always holds zero
	assign debugWbRfWdata = (hz.writeRegW == '0) ? '0 : resultW;

endmodule

//--- logic/hazardIf.sv
`timescale 1ns/10ps

interface hazardIf;

	// decode stage
	mipsPkg::regNum rsD;
	mipsPkg::regNum rtD;
	logic branchD;
	logic redirectD;
	// execute stage
	mipsPkg::regNum rsE;
	mipsPkg::regNum rtE;
	mipsPkg::regNum writeRegE;
	logic regWriteE;
	logic memToRegE;
	// memory and writeback
	mipsPkg::regNum writeRegM;
	logic regWriteM;
	logic memToRegM;
	mipsPkg::regNum writeRegW;
	logic regWriteW;

	// controls back to the pipe
	logic forwardAD, forwardBD;
	mipsPkg::fwdSel forwardAE, forwardBE;
	logic stallF, stallD, stallE, stallM, stallW;
	logic flushD, flushE;

	modport pipe (
		output rsD, rtD, branchD, redirectD,
		output rsE, rtE, writeRegE, regWriteE, memToRegE,
		output writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		input forwardAD, forwardBD, forwardAE, forwardBE,
		input stallF, stallD, stallE, stallM, stallW, flushD, flushE
	);

	modport ctrl (
		input rsD, rtD, branchD, redirectD,
		input rsE, rtE, writeRegE, regWriteE, memToRegE,
		input writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		output forwardAD, forwardBD, forwardAE, forwardBE,
		output stallF, stallD, stallE, stallM, stallW, flushD, flushE
	);

endinterface

//--- logic/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
	input logic iStall,
	input logic dStall,
	output logic longestStall,
	hazardIf.ctrl hz
);

	logic lwStall, branchStall, pipeStall;

	// memory stage wins over writeback, $0 never forwards
	function automatic mipsPkg::fwdSel selectFwd(input mipsPkg::regNum src,
			input logic wenM, input mipsPkg::regNum dstM,
			input logic wenW, input mipsPkg::regNum dstW);
		if (src != '0 && wenM && src == dstM)
			return mipsPkg::FWD_MEM;
		else if (src != '0 && wenW && src == dstW)
			return mipsPkg::FWD_WB;
		else
			return mipsPkg::FWD_REG;
	endfunction

	//////////////////////////////
	// forwarding
	assign hz.forwardAE = selectFwd(hz.rsE, hz.regWriteM, hz.writeRegM,
		hz.regWriteW, hz.writeRegW);
	assign hz.forwardBE = selectFwd(hz.rtE, hz.regWriteM, hz.writeRegM,
		hz.regWriteW, hz.writeRegW);

	// decode compare only reads from memory stage
	assign hz.forwardAD = (hz.rsD != '0) && hz.regWriteM && (hz.rsD == hz.writeRegM);
	assign hz.forwardBD = (hz.rtD != '0) && hz.regWriteM && (hz.rtD == hz.writeRegM);

	//////////////////////////////
	// stalls and flushes
	assign lwStall = hz.memToRegE &&
		(hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD);

	// beq waits until its operands sit in memory stage as alu results
	assign branchStall = hz.branchD &&
		((hz.regWriteE && (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD)) ||
		(hz.memToRegM && (hz.writeRegM == hz.rsD || hz.writeRegM == hz.rtD)));

	assign longestStall = iStall | dStall;
	assign pipeStall = lwStall | branchStall;

	assign hz.stallF = pipeStall | longestStall;
	assign hz.stallD = pipeStall | longestStall;
	assign hz.stallE = longestStall;
	assign hz.stallM = longestStall;
	assign hz.stallW = longestStall;

	// the pipe applies these only while its stage is enabled
	assign hz.flushD = hz.redirectD;
	assign hz.flushE = pipeStall;

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
	input logic clk,
	input logic reset,
	input mipsPkg::word instrF,
	input mipsPkg::word readDataM,
	input logic iStall,
	input logic dStall,
	output mipsPkg::word pcF,
	output logic memWriteM,
	output mipsPkg::word aluOutM,
	output mipsPkg::word writeDataM,
	output logic longestStall,
	output mipsPkg::word debugWbPc,
	output logic [3:0] debugWbRfWen,
	output mipsPkg::regNum debugWbRfWnum,
	output mipsPkg::word debugWbRfWdata
);

	hazardIf hz ();

	datapath dp (
		.clk(clk), .reset(reset),
		.instrF(instrF), .readDataM(readDataM), .stallMem(longestStall),
		.pcF(pcF), .memWriteM(memWriteM), .aluOutM(aluOutM), .writeDataM(writeDataM),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata),
		.hz(hz.pipe)
	);

	hazardUnit hu (
		.iStall(iStall), .dStall(dStall), .longestStall(longestStall),
		.hz(hz.ctrl)
	);

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

	// word and field types
	typedef logic [31:0] word;
	typedef logic [4:0] regNum;
	typedef logic [5:0] opcode;
	typedef logic [5:0] functCode;

	//////////////////////////////
	// primary opcodes
	localparam opcode OP_RTYPE = 6'b000000;
	localparam opcode OP_ADDIU = 6'b001001;
	localparam opcode OP_LW    = 6'b100011;
	localparam opcode OP_SW    = 6'b101011;
	localparam opcode OP_BEQ   = 6'b000100;
	localparam opcode OP_J     = 6'b000010;

	// r-type function codes
	localparam functCode FN_ADDU = 6'b100001;
	localparam functCode FN_SUBU = 6'b100011;
	localparam functCode FN_AND  = 6'b100100;
	localparam functCode FN_OR   = 6'b100101;
	localparam functCode FN_SLT  = 6'b101010;

	//////////////////////////////
	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp;

	// forward source for an execute operand
	typedef enum logic [1:0] {FWD_REG, FWD_WB, FWD_MEM} fwdSel;

	localparam word RESET_PC = 32'h0000_0000;

endpackage

//--- logic/regFile.sv
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic we,
	input mipsPkg::regNum ra1,
	input mipsPkg::regNum ra2,
	input mipsPkg::regNum wa,
	input mipsPkg::word wd,
	output mipsPkg::word rd1,
	output mipsPkg::word rd2
);

	mipsPkg::word regs [32];

	// $0 is never written
	always_ff @(posedge clk) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end

	// write-first, so decode sees the writeback value in the same cycle
	assign rd1 = (ra1 == '0) ? '0 : (we && ra1 == wa) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && ra2 == wa) ? wd : regs[ra2];

endmodule

//--- project.f
logic/mipsPkg.sv
logic/hazardIf.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/datapath.sv
logic/hazardUnit.sv
logic/mipsCore.sv
verif/mipsCore_assertions.sv
verif/tb_mipsCore.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_mipsCore -f project.f -o simv \
	&& ./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0

//--- verif/mipsCore_assertions.sv
`timescale 1ns/10ps

module mipsCoreAssertions (
	input logic clk,
	input logic reset,
	input mipsPkg::word pcF,
	input logic memWriteM,
	input logic longestStall,
	input logic fetchStall,
	input logic redirect,
	input logic [3:0] debugWbRfWen,
	input mipsPkg::regNum debugWbRfWnum,
	input mipsPkg::word debugWbRfWdata
);

	int failCount = 0;

	//////////////////////////////
	// first cycle out of reset
	resetState: assert property (@(posedge clk) $fell(reset) |->
		(pcF == mipsPkg::RESET_PC && !memWriteM && debugWbRfWen == 4'b0000 && !longestStall))
	else begin
		failCount++;
		$error("core is not idle in the first cycle after reset");
	end

	// sequential fetch when nothing redirects or stalls
	seqFetch: assert property (@(posedge clk) disable iff (reset)
		(!fetchStall && !redirect) |=> (pcF == $past(pcF) + 32'd4))
	else begin
		failCount++;
		$error("pc did not advance by 4");
	end

	//////////////////////////////
	// memory stall freezes fetch and hides writeback
	stallHold: assert property (@(posedge clk) disable iff (reset)
		longestStall |=> $stable(pcF))
	else begin
		failCount++;
		$error("pc moved during a memory stall");
	end

	stallNoWb: assert property (@(posedge clk) disable iff (reset)
		longestStall |-> (debugWbRfWen == 4'b0000))
	else begin
		failCount++;
		$error("writeback reported during a memory stall");
	end

	// enable lanes move together
	wenLanes: assert property (@(posedge clk) disable iff (reset)
		(debugWbRfWen == 4'b0000 || debugWbRfWen == 4'b1111))
	else begin
		failCount++;
		$error("writeback enable lanes disagree");
	end

	zeroReg: assert property (@(posedge clk) disable iff (reset)
		(debugWbRfWen != 4'b0000 && debugWbRfWnum == '0) |-> (debugWbRfWdata == '0))
	else begin
		failCount++;
		$error("register 0 reported a nonzero write");
	end

endmodule

//--- verif/tb_mipsCore.sv
`timescale 1ns/10ps

module tb_mipsCore;

	localparam int PROG_LEN = 19;
	localparam int STALL_STRETCH = 8;
	localparam int WATCH_CYCLES = 20 * PROG_LEN * STALL_STRETCH;

	logic clk = 1'b0;
	logic reset;
	logic iStall = 1'b0;
	logic dStall = 1'b0;
	logic stallsOn;
	mipsPkg::word instrF, readDataM, pcF, aluOutM, writeDataM;
	mipsPkg::word debugWbPc, debugWbRfWdata;
	logic memWriteM, longestStall;
	logic [3:0] debugWbRfWen;
	mipsPkg::regNum debugWbRfWnum;

	mipsPkg::word rom [32];
	mipsPkg::word ram [64];
	// reference model state
	mipsPkg::word isaRegs [32];
	mipsPkg::word isaMem [64];
	logic executed [32];
	mipsPkg::word expPc [$];
	mipsPkg::regNum expNum [$];
	mipsPkg::word expData [$];
	mipsPkg::word stAddr [$];
	mipsPkg::word stData [$];
	logic [31:0] seed = 32'h318658b8;
	int errors = 0;
	int traceIdx = 0;
	int storeIdx = 0;

	mipsCore i_dut (
		.clk(clk), .reset(reset), .instrF(instrF), .readDataM(readDataM),
		.iStall(iStall), .dStall(dStall), .pcF(pcF), .memWriteM(memWriteM),
		.aluOutM(aluOutM), .writeDataM(writeDataM), .longestStall(longestStall),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	bind mipsCore mipsCoreAssertions checks (
		.clk(clk), .reset(reset), .pcF(pcF), .memWriteM(memWriteM),
		.longestStall(longestStall), .fetchStall(hz.stallF), .redirect(hz.redirectD),
		.debugWbRfWen(debugWbRfWen), .debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] nextRand(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic mipsPkg::word fillWord(input int index);
		return 32'hA5C3_0000 ^ (32'(index) << 2) ^ (32'(index) << 18);
	endfunction

	function automatic mipsPkg::word rType(input mipsPkg::functCode fn,
			input mipsPkg::regNum rd, input mipsPkg::regNum rs, input mipsPkg::regNum rt);
		return {mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mipsPkg::word iType(input mipsPkg::opcode op,
			input mipsPkg::regNum rt, input mipsPkg::regNum rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsPkg::word jType(input logic [25:0] target);
		return {mipsPkg::OP_J, target};
	endfunction

	task automatic checkValue(input string name, input mipsPkg::word expected,
			input mipsPkg::word actual);
		assert (actual == expected)
		else begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	//////////////////////////////
	// program, no nops between dependent instructions
	task automatic loadProgram();
		int i;
		for (i = 0; i < 32; i++)
			rom[i] = '0;
		rom[0] = iType(mipsPkg::OP_ADDIU, 5'd1, 5'd0, 16'd5);
		rom[1] = iType(mipsPkg::OP_ADDIU, 5'd2, 5'd1, 16'd7);
		rom[2] = rType(mipsPkg::FN_ADDU, 5'd3, 5'd1, 5'd2);
		rom[3] = rType(mipsPkg::FN_SUBU, 5'd4, 5'd3, 5'd1);
		rom[4] = rType(mipsPkg::FN_OR, 5'd5, 5'd3, 5'd2);
		rom[5] = rType(mipsPkg::FN_SLT, 5'd6, 5'd1, 5'd3);
		rom[6] = iType(mipsPkg::OP_SW, 5'd3, 5'd0, 16'd8);
		rom[7] = iType(mipsPkg::OP_LW, 5'd7, 5'd0, 16'd8);
		// load-use, then a beq on the fresh result
		rom[8] = rType(mipsPkg::FN_ADDU, 5'd8, 5'd7, 5'd1);
		rom[9] = iType(mipsPkg::OP_BEQ, 5'd1, 5'd8, 16'd2);
		rom[10] = iType(mipsPkg::OP_BEQ, 5'd2, 5'd4, 16'd1);
		rom[11] = iType(mipsPkg::OP_ADDIU, 5'd9, 5'd0, 16'd99);
		rom[12] = rType(mipsPkg::FN_AND, 5'd10, 5'd3, 5'd6);
		rom[13] = jType(26'd15);
		rom[14] = iType(mipsPkg::OP_ADDIU, 5'd11, 5'd0, 16'd77);
		rom[15] = iType(mipsPkg::OP_ADDIU, 5'd12, 5'd7, 16'hFFFD);
		// write to $0, then read $0 while it sits in memory stage
		rom[16] = iType(mipsPkg::OP_ADDIU, 5'd0, 5'd12, 16'd1);
		rom[17] = rType(mipsPkg::FN_ADDU, 5'd13, 5'd0, 5'd12);
		rom[18] = jType(26'd18);
	endtask

	// walk the program one instruction at a time to get the expected trace
	task automatic buildTrace();
		mipsPkg::word pc, pcPlus4, ins, a, b, imm, addr, res, nextPc;
		mipsPkg::regNum dst;
		logic wr;
		int i;
		for (i = 0; i < 32; i++) begin
			isaRegs[i] = '0;
			executed[i] = 1'b0;
		end
		for (i = 0; i < 64; i++)
			isaMem[i] = fillWord(i);
		pc = mipsPkg::RESET_PC;
		for (i = 0; i < 4 * PROG_LEN; i++) begin
			ins = rom[pc[6:2]];
			executed[pc[6:2]] = 1'b1;
			a = isaRegs[ins[25:21]];
			b = isaRegs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			pcPlus4 = pc + 32'd4;
			nextPc = pcPlus4;
			dst = ins[20:16];
			res = '0;
			wr = 1'b0;
			case (ins[31:26])
				mipsPkg::OP_RTYPE: begin
					dst = ins[15:11];
					wr = 1'b1;
					case (ins[5:0])
						mipsPkg::FN_ADDU: res = a + b;
						mipsPkg::FN_SUBU: res = a - b;
						mipsPkg::FN_AND: res = a & b;
						mipsPkg::FN_OR: res = a | b;
						mipsPkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				mipsPkg::OP_ADDIU: begin
					res = addr;
					wr = 1'b1;
				end
				mipsPkg::OP_LW: begin
					res = isaMem[addr[7:2]];
					wr = 1'b1;
				end
				mipsPkg::OP_SW: begin
					isaMem[addr[7:2]] = b;
					stAddr.push_back(addr);
					stData.push_back(b);
				end
				mipsPkg::OP_BEQ: begin
					if (a == b)
						nextPc = pcPlus4 + (imm << 2);
				end
				mipsPkg::OP_J: nextPc = {pcPlus4[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			if (wr) begin
				if (dst != '0)
					isaRegs[dst] = res;
				expPc.push_back(pc);
				expNum.push_back(dst);
				// $0 keeps zero
				expData.push_back(isaRegs[dst]);
			end
			// spin loop reached
			if (nextPc == pc)
				break;
			pc = nextPc;
		end
	endtask

	//////////////////////////////
	// memories answer in the same cycle
	assign instrF = rom[pcF[6:2]];
	assign readDataM = ram[aluOutM[7:2]];

	always @(posedge clk) begin : ramWrite
		int i;
		if (reset) begin
			for (i = 0; i < 64; i++)
				ram[i] <= fillWord(i);
		end else if (memWriteM && !longestStall) begin
			ram[aluOutM[7:2]] <= writeDataM;
		end
	end

	// about one cycle in eight stalls
	always @(posedge clk) begin
		seed <= nextRand(seed);
		iStall <= stallsOn && seed[31:29] == 3'd0 && seed[28];
		dStall <= stallsOn && seed[31:29] == 3'd0 && !seed[28];
	end

	//////////////////////////////
	// trace and store checks, mid-cycle
	always @(negedge clk) begin
		if (!reset)
			checkValue("longest stall", 32'(iStall | dStall), 32'(longestStall));
		if (!reset && debugWbRfWen != 4'b0000) begin
			assert (executed[debugWbPc[6:2]])
			else begin
				errors++;
				$display("register write reported from pc %h, which is squashed", debugWbPc);
			end
			assert (traceIdx < expPc.size())
			else begin
				errors++;
				$display("extra register write from pc %h after the trace ended", debugWbPc);
			end
			if (traceIdx < expPc.size()) begin
				checkValue("trace pc", expPc[traceIdx], debugWbPc);
				checkValue("trace register", 32'(expNum[traceIdx]), 32'(debugWbRfWnum));
				checkValue("trace data", expData[traceIdx], debugWbRfWdata);
				traceIdx++;
			end
		end
		if (!reset && memWriteM && !longestStall) begin
			assert (storeIdx < stAddr.size())
			else begin
				errors++;
				$display("unexpected store to address %h", aluOutM);
			end
			if (storeIdx < stAddr.size()) begin
				checkValue("store address", stAddr[storeIdx], aluOutM);
				checkValue("store data", stData[storeIdx], writeDataM);
				storeIdx++;
			end
		end
	end

	initial begin
		reset = 1'b1;
		stallsOn = 1'b0;
		loadProgram();
		buildTrace();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		stallsOn <= 1'b1;
		while (traceIdx < expPc.size())
			@(posedge clk);
		// let the spin loop run to catch late writes
		repeat (12) @(posedge clk);
		if (storeIdx != stAddr.size())
			$display("only %0d of %0d stores reached memory", storeIdx, stAddr.size());
		$display("check errors: %0d, assertion failures: %0d, missing stores: %0d",
			errors, i_dut.checks.failCount, stAddr.size() - storeIdx);
		if (errors == 0 && i_dut.checks.failCount == 0 && storeIdx == stAddr.size())
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCH_CYCLES * 8);
		$display("timeout: writeback trace not complete after %0d cycles", WATCH_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule
